// ==== prei.f ====
hw/prei_pkg.sv
hw/prei_ram_dp_16x32.sv
hw/prei_adr_cnt.sv
hw/prei_ctrl.sv
hw/prei_dc_sum.sv
hw/prei_sad.sv
hw/prei_top.sv
bench/tb_prei.sv

// ==== Bender.yml ====
package:
  name: prei

sources:
  # rtl, package first
  - hw/prei_pkg.sv
  - hw/prei_ram_dp_16x32.sv
  - hw/prei_adr_cnt.sv
  - hw/prei_ctrl.sv
  - hw/prei_dc_sum.sv
  - hw/prei_sad.sv
  - hw/prei_top.sv
  # testbench
  - target: simulation
    files:
      - bench/tb_prei.sv

// ==== bench/prei_vectors.txt ====
// one 8x8 block per two lines: words 0..7, then words 8..15, dc, sad
// word = four pixels, first pixel in the low byte; all fields hex
// flat mid grey, sad zero
80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080
80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080 80 0000
// all 255
FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF
FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FF 0000
// checkerboard 0 / 255
FF00FF00 FF00FF00 00FF00FF 00FF00FF FF00FF00 FF00FF00 00FF00FF 00FF00FF
FF00FF00 FF00FF00 00FF00FF 00FF00FF FF00FF00 FF00FF00 00FF00FF 00FF00FF 80 1FE0
// all zero
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00 0000
// word ramp 0x00..0xF0
00000000 10101010 20202020 30303030 40404040 50505050 60606060 70707070
80808080 90909090 A0A0A0A0 B0B0B0B0 C0C0C0C0 D0D0D0D0 E0E0E0E0 F0F0F0F0 78 1000
// one bright pixel on a dark field
101010FF 10101010 10101010 10101010 10101010 10101010 10101010 10101010
10101010 10101010 10101010 10101010 10101010 10101010 10101010 10101010 14 01E7
// sum 32, rounds up to dc 1
01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 01 0020
// sum 31, rounds down to dc 0
01010101 01010101 01010101 01010101 01010101 01010101 01010101 00010101
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00 001F
// pixels 1,2,3,4 in every word
04030201 04030201 04030201 04030201 04030201 04030201 04030201 04030201
04030201 04030201 04030201 04030201 04030201 04030201 04030201 04030201 03 0040

// ==== bench/tb_prei.sv ====
// tb_prei: self-checking testbench, file blocks, lfsr blocks, latency and noise checks

module tb_prei
	import prei_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int VEC_COLS     = WORDS_PER_BLK + 2; // 16 words, dc, sad
	localparam int MAX_FILE_BLK = 16;
	localparam int N_RAND       = 8;
	localparam int LATENCY      = 35;  // cycles from last write to done_o
	localparam int TIMEOUT      = 200; // per wait loop

	logic  clk;
	logic  arst_n_i;
	logic  start_i;
	logic  org_vld_i;
	word_t org_dat_i;
	logic  busy_o;
	logic  done_o;
	pix_t  dc_o;
	sad_t  sad_o;

	word_t       vec_mem [0:VEC_COLS*MAX_FILE_BLK-1];
	word_t       blk [WORDS_PER_BLK]; // block under test
	logic [15:0] lfsr_q;
	int          err_cnt;
	int          chk_cnt;
	int          test_cnt;
	int          test_bad;

	prei_top prei_top_i (
		.clk       ( clk       ),
		.arst_n_i  ( arst_n_i  ),
		.start_i   ( start_i   ),
		.org_vld_i ( org_vld_i ),
		.org_dat_i ( org_dat_i ),
		.busy_o    ( busy_o    ),
		.done_o    ( done_o    ),
		.dc_o      ( dc_o      ),
		.sad_o     ( sad_o     )
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns
	end

	// ------------------------------------------------------------
	// random bits and expected values
	// ------------------------------------------------------------

	// fibonacci, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()}; // one step per bit
		end
		return v;
	endfunction

	// rounded mean of the 64 pixels
	function automatic pix_t ref_dc();
		int sum;
		sum = 0;
		for (int w = 0; w < WORDS_PER_BLK; w++) begin
			for (int p = 0; p < 4; p++) begin
				sum += int'(blk[w][8*p +: 8]);
			end
		end
		return pix_t'((sum + 32) / 64);
	endfunction

	function automatic sad_t ref_sad(input pix_t dc);
		int sad;
		int d;
		sad = 0;
		for (int w = 0; w < WORDS_PER_BLK; w++) begin
			for (int p = 0; p < 4; p++) begin
				d    = int'(blk[w][8*p +: 8]) - int'(dc);
				sad += (d < 0) ? -d : d;
			end
		end
		return sad_t'(sad);
	endfunction

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------

	task automatic check_dc(input pix_t got, input pix_t exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR dc_o: got 0x%h exp 0x%h", got, exp);
		end
	endtask

	task automatic check_sad(input sad_t got, input sad_t exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR sad_o: got 0x%h exp 0x%h", got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %s: got 0x%h exp 0x%h", name, got, exp);
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		test_cnt++;
		if (err_cnt == err_before) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			test_bad++;
			$display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
		end
	endtask

	// ------------------------------------------------------------
	// drive and wait
	// ------------------------------------------------------------

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy_o !== 1'b0 && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (busy_o !== 1'b0) begin
			err_cnt++;
			$display("timeout: busy_o still high after %0d cycles", TIMEOUT);
		end
	endtask

	// strobes and junk words while idle, all to be dropped
	task automatic idle_noise();
		repeat (8) begin
			@(posedge clk);
			org_vld_i <= lfsr_bit();
			org_dat_i <= rand_bits(32);
			@(negedge clk);
			check_flag("busy_o", busy_o, 1'b0); // strobes alone never start a block
		end
	endtask

	// start pulse, then 16 words, optional random gaps
	// returns right after driving the 16th strobe
	task automatic load_block(input bit gaps);
		@(posedge clk);
		start_i   <= 1'b1;
		org_vld_i <= 1'b0;
		@(posedge clk);
		start_i <= 1'b0;
		for (int w = 0; w < WORDS_PER_BLK; w++) begin
			if (gaps) begin
				repeat (rand_bits(2)) begin
					org_vld_i <= 1'b0;
					org_dat_i <= rand_bits(32); // must not be written
					@(posedge clk);
				end
			end
			org_vld_i <= 1'b1;
			org_dat_i <= blk[w];
			if (w != WORDS_PER_BLK - 1) begin
				@(posedge clk);
			end
		end
	endtask

	// counts cycles after the 16th write until done_o
	task automatic wait_done(input bit noise, output int lat);
		lat = 0;
		do begin
			@(posedge clk);
			org_vld_i <= noise && lfsr_bit();
			start_i   <= noise && (lat < 30) && lfsr_bit(); // stays clear of DONE
			org_dat_i <= noise ? rand_bits(32) : '0;
			@(negedge clk);
			lat++;
		end while (done_o !== 1'b1 && lat < TIMEOUT);
		if (done_o !== 1'b1) begin
			err_cnt++;
			$display("timeout: no done_o within %0d cycles of the last write", TIMEOUT);
		end
	endtask

	task automatic run_block(input bit gaps, input bit noise, input pix_t exp_dc,
	                         input sad_t exp_sad);
		int lat;
		wait_idle();
		load_block(gaps);
		wait_done(noise, lat);
		if (done_o === 1'b1) begin
			if (lat != LATENCY) begin
				err_cnt++;
				$display("done_o came %0d cycles after the last write, not %0d", lat, LATENCY);
			end
			check_flag("busy_o", busy_o, 1'b1); // still busy in DONE
			@(posedge clk);
			start_i   <= 1'b0;
			org_vld_i <= 1'b0;
			@(negedge clk);
			check_flag("done_o", done_o, 1'b0); // one cycle only
			check_flag("busy_o", busy_o, 1'b0);
			check_dc(dc_o, exp_dc);
			check_sad(sad_o, exp_sad);
		end
	endtask

	task automatic fill_random();
		for (int w = 0; w < WORDS_PER_BLK; w++) begin
			blk[w] = rand_bits(32);
		end
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------

	initial begin
		int   eb;
		int   nfile;
		pix_t dc;
		arst_n_i  = 1'b0;
		start_i   = 1'b0;
		org_vld_i = 1'b0;
		org_dat_i = '0;
		lfsr_q    = 16'd65;
		err_cnt   = 0;
		chk_cnt   = 0;
		test_cnt  = 0;
		test_bad  = 0;
		nfile     = 0;
		for (int i = 0; i < VEC_COLS * MAX_FILE_BLK; i++) begin
			vec_mem[i] = '1; // dc field of all ones marks no block
		end
		$readmemh("bench/prei_vectors.txt", vec_mem);

		repeat (4) @(posedge clk);
		arst_n_i <= 1'b1;

		// 1: reset state
		eb = err_cnt;
		@(negedge clk);
		check_flag("busy_o", busy_o, 1'b0);
		check_flag("done_o", done_o, 1'b0);
		check_dc(dc_o, '0);
		check_sad(sad_o, '0);
		end_test("reset values", eb);

		// 2: file blocks, back-to-back strobes
		for (int b = 0; b < MAX_FILE_BLK; b++) begin
			if (vec_mem[b*VEC_COLS + 16] === '1) break;
			eb = err_cnt;
			for (int w = 0; w < WORDS_PER_BLK; w++) begin
				blk[w] = vec_mem[b*VEC_COLS + w];
			end
			run_block(1'b0, 1'b0, pix_t'(vec_mem[b*VEC_COLS + 16]),
			          sad_t'(vec_mem[b*VEC_COLS + 17]));
			end_test($sformatf("file block %0d", b), eb);
			nfile++;
		end
		if (nfile == 0) begin
			err_cnt++;
			$display("no blocks were read from bench/prei_vectors.txt");
		end

		// 3: lfsr blocks, gaps in the strobes
		for (int r = 0; r < N_RAND; r++) begin
			eb = err_cnt;
			fill_random();
			dc = ref_dc();
			run_block(1'b1, 1'b0, dc, ref_sad(dc));
			end_test($sformatf("lfsr block %0d", r), eb);
		end

		// 4: latency and done width on a gapped load
		eb = err_cnt;
		fill_random();
		dc = ref_dc();
		run_block(1'b1, 1'b0, dc, ref_sad(dc));
		end_test("done latency", eb);

		// 5: strobes while idle, then strobes and start while busy
		eb = err_cnt;
		fill_random();
		dc = ref_dc();
		idle_noise();
		run_block(1'b0, 1'b0, dc, ref_sad(dc));
		end_test("noise while idle", eb);
		eb = err_cnt;
		fill_random();
		dc = ref_dc();
		run_block(1'b1, 1'b1, dc, ref_sad(dc));
		end_test("noise while busy", eb);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
		         test_cnt, test_bad, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== hw/prei_top.sv ====
// prei_top: original-pixel stage, controller, address counter, ram, dc and sad datapath

module prei_top
	import prei_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n_i,
	input  logic  start_i,   // one-cycle pulse
	input  logic  org_vld_i, // loader write strobe
	input  word_t org_dat_i, // four pixels, first in low byte
	output logic  busy_o,
	output logic  done_o,    // one-cycle pulse
	output pix_t  dc_o,
	output sad_t  sad_o
);

	// ------------------------------------------------------------
	// internal wires
	// ------------------------------------------------------------

	logic  cnt_clr;
	logic  cnt_inc;
	logic  cnt_last;
	adr_t  cnt_adr;  // shared by write and read port
	logic  ram_wr_n; // low active
	logic  ram_rd_n; // low active, raw pass read strobe
	word_t ram_dat;
	logic  sum_clr;
	logic  sad_clr;
	pix_t  dc_val;

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------

	prei_ctrl u_ctrl (
		.clk        ( clk       ),
		.arst_n_i   ( arst_n_i  ),
		.start_i    ( start_i   ),
		.org_vld_i  ( org_vld_i ),
		.cnt_last_i ( cnt_last  ),
		.cnt_clr_o  ( cnt_clr   ),
		.cnt_inc_o  ( cnt_inc   ),
		.ram_wr_n_o ( ram_wr_n  ),
		.ram_rd_n_o ( ram_rd_n  ),
		.sum_clr_o  ( sum_clr   ),
		.sad_clr_o  ( sad_clr   ),
		.busy_o     ( busy_o    ),
		.done_o     ( done_o    )
	);

	prei_adr_cnt u_adr_cnt (
		.clk      ( clk      ),
		.arst_n_i ( arst_n_i ),
		.clr_i    ( cnt_clr  ),
		.inc_i    ( cnt_inc  ),
		.adr_o    ( cnt_adr  ),
		.last_o   ( cnt_last )
	);

	// ------------------------------------------------------------
	// block store
	// ------------------------------------------------------------

	prei_ram_dp_16x32 u_ram (
		.clk      ( clk       ),
		.wr_ena_i ( ram_wr_n  ),
		.wr_adr_i ( cnt_adr   ),
		.wr_dat_i ( org_dat_i ),
		.rd_ena_i ( ram_rd_n  ),
		.rd_adr_i ( cnt_adr   ),
		.rd_dat_o ( ram_dat   )
	);

	// ------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------

	prei_dc_sum u_dc_sum (
		.clk      ( clk      ),
		.arst_n_i ( arst_n_i ),
		.clr_i    ( sum_clr  ),
		.rd_ena_i ( ram_rd_n ),
		.rd_dat_i ( ram_dat  ),
		.dc_o     ( dc_val   )
	);

	prei_sad u_sad (
		.clk      ( clk      ),
		.arst_n_i ( arst_n_i ),
		.clr_i    ( sad_clr  ),
		.rd_ena_i ( ram_rd_n ),
		.rd_dat_i ( ram_dat  ),
		.dc_i     ( dc_val   ),
		.sad_o    ( sad_o    )
	);

	assign dc_o = dc_val;

endmodule

// ==== hw/prei_sad.sv ====
// prei_sad: sum of absolute pixel-minus-dc differences over the second read pass

module prei_sad
	import prei_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n_i,
	input  logic  clr_i,    // start of sad pass
	input  logic  rd_ena_i, // ram read strobe, low active
	input  word_t rd_dat_i, // ram read data
	input  pix_t  dc_i,     // from prei_dc_sum, settled before this pass
	output sad_t  sad_o
);

	logic rd_vld;   // rd_dat_i carries a word this cycle
	logic armed;    // inside the sad pass
	logic last;     // final word of the pass
	sad_t word_sad; // four abs differences of the current word
	sad_t acc;

	// ------------------------------------------------------------
	// abs difference per pixel
	// ------------------------------------------------------------

	always_comb begin
		pix_t pix;
		pix      = '0;
		word_sad = '0;
		for (int i = 0; i < PIX_PER_WORD; i++) begin
			pix = rd_dat_i[i*$bits(pix_t) +: $bits(pix_t)];
			if (pix > dc_i) begin
				word_sad += sad_t'(pix - dc_i);
			end else begin
				word_sad += sad_t'(dc_i - pix);
			end
		end
	end

	// end of the valid run, same scheme as prei_dc_sum
	assign last = armed && rd_vld && rd_ena_i;

	// ------------------------------------------------------------
	// accumulator
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_vld <= 1'b0;
			armed  <= 1'b0;
			acc    <= '0;
		end else begin
			rd_vld <= !rd_ena_i;
			if (clr_i) begin
				armed <= 1'b1; // last sum word on rd_dat_i is skipped
				acc   <= '0;
			end else if (armed && rd_vld) begin
				acc <= acc + word_sad; // 64*255 max, fits sad_t
				if (last) armed <= 1'b0;
			end
		end
	end

	assign sad_o = acc; // holds once disarmed

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	// dc from the sum pass must not move under the sad pass
	dc_stable_a : assert property (
		@(posedge clk) disable iff (!arst_n_i)
		(armed && rd_vld) |-> $stable(dc_i)
	) else $error("prei_sad: dc_i changed during sad pass");

endmodule

// ==== hw/prei_dc_sum.sv ====
// prei_dc_sum: block pixel sum over the first read pass and rounded dc value

module prei_dc_sum
	import prei_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n_i,
	input  logic  clr_i,    // start of sum pass
	input  logic  rd_ena_i, // ram read strobe, low active
	input  word_t rd_dat_i, // ram read data
	output pix_t  dc_o      // holds until the next sum pass ends
);

	logic rd_vld;   // rd_dat_i carries a word this cycle
	logic armed;    // inside the sum pass
	logic last;     // final word of the pass on rd_dat_i
	sum_t word_sum; // four pixels of the current word
	sum_t acc;
	sum_t rnd_sum;  // running sum incl. this word, rounded

	// ------------------------------------------------------------
	// word adder
	// ------------------------------------------------------------

	always_comb begin
		word_sum = '0;
		for (int i = 0; i < PIX_PER_WORD; i++) begin
			word_sum += sum_t'(rd_dat_i[i*$bits(pix_t) +: $bits(pix_t)]);
		end
	end

	// max 64*255 + 32 still fits sum_t
	assign rnd_sum = acc + word_sum + sum_t'(DC_ROUND);

	// reads are back to back, so a valid word with no read behind it
	// is the 16th one
	assign last = armed && rd_vld && rd_ena_i;

	// ------------------------------------------------------------
	// control and dc register
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_vld <= 1'b0;
			armed  <= 1'b0;
			dc_o   <= '0;
		end else begin
			rd_vld <= !rd_ena_i; // one-cycle ram latency
			if (clr_i) begin
				armed <= 1'b1;
			end else if (last) begin
				armed <= 1'b0; // sad pass reads pass by untouched
				dc_o  <= pix_t'(rnd_sum >> DC_SHIFT);
			end
		end
	end

	// accumulator, cleared per pass
	always_ff @(posedge clk) begin
		if (clr_i) begin
			acc <= '0;
		end else if (armed && rd_vld) begin
			acc <= acc + word_sum;
		end
	end

endmodule

// ==== hw/prei_ctrl.sv ====
// prei_ctrl: FSM for block load, sum pass, sad pass and done strobe

module prei_ctrl
	import prei_pkg::*;
(
	input  logic clk,
	input  logic arst_n_i,
	input  logic start_i,    // one-cycle, ignored while busy
	input  logic org_vld_i,  // loader write strobe
	input  logic cnt_last_i, // counter at word 15
	output logic cnt_clr_o,
	output logic cnt_inc_o,
	output logic ram_wr_n_o, // low active
	output logic ram_rd_n_o, // low active, also the datapath read strobe
	output logic sum_clr_o,  // arms prei_dc_sum
	output logic sad_clr_o,  // arms prei_sad
	output logic busy_o,
	output logic done_o
);

	prei_state_e state;
	logic        drain;   // wait cycle after the 16th read
	logic        load_wr; // accepted loader word
	logic        pass_rd; // read issued this cycle

	// ------------------------------------------------------------
	// strobes
	// ------------------------------------------------------------

	assign load_wr = (state == LOAD) && org_vld_i; // strobes outside LOAD dropped
	assign pass_rd = ((state == SUM) || (state == SAD)) && !drain;

	assign ram_wr_n_o = !load_wr;
	assign ram_rd_n_o = !pass_rd;
	assign cnt_inc_o  = load_wr || pass_rd; // one word per write or read

	// counter already wrapped to 0 after word 15,
	// clear again at start and in each drain cycle anyway
	assign cnt_clr_o = ((state == IDLE) && start_i) || drain;

	// sum pass armed by the final load word
	assign sum_clr_o = load_wr && cnt_last_i;
	// sad pass armed while the last sum word drains
	assign sad_clr_o = (state == SUM) && drain;

	assign busy_o = (state != IDLE); // covers DONE, falls after it
	assign done_o = (state == DONE);

	// ------------------------------------------------------------
	// state register
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= IDLE;
			drain <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (start_i) state <= LOAD;
				end
				LOAD: begin
					if (load_wr && cnt_last_i) state <= SUM; // 16th word written
				end
				SUM, SAD: begin
					if (drain) begin
						drain <= 1'b0;
						state <= (state == SUM) ? SAD : DONE;
					end else if (cnt_last_i) begin
						drain <= 1'b1; // 16 reads out, let the last one land
					end
				end
				DONE: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	done_pulse_a : assert property (
		@(posedge clk) disable iff (!arst_n_i)
		done_o |=> !done_o
	) else $error("prei_ctrl: done_o longer than one cycle");

	wr_rd_excl_a : assert property (
		@(posedge clk) disable iff (!arst_n_i)
		!(!ram_wr_n_o && !ram_rd_n_o)
	) else $error("prei_ctrl: ram write and read both enabled");

endmodule

// ==== hw/prei_adr_cnt.sv ====
// prei_adr_cnt: word address counter for load and read passes, last-word flag

module prei_adr_cnt
	import prei_pkg::*;
(
	input  logic clk,
	input  logic arst_n_i,
	input  logic clr_i,  // back to word 0, wins over inc_i
	input  logic inc_i,  // step one word
	output adr_t adr_o,
	output logic last_o  // at LAST_ADR
);

	adr_t adr;

	// ------------------------------------------------------------
	// counter
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			adr <= '0;
		end else if (clr_i) begin
			adr <= '0;
		end else if (inc_i) begin
			if (adr == adr_t'(LAST_ADR)) begin
				adr <= '0; // wrap, next pass starts at 0
			end else begin
				adr <= adr + adr_t'(1);
			end
		end
	end

	assign adr_o  = adr;
	assign last_o = (adr == adr_t'(LAST_ADR)); // 16th word of the pass

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	// controller never steps and clears together
	clr_inc_excl_a : assert property (
		@(posedge clk) disable iff (!arst_n_i)
		!(clr_i && inc_i)
	) else $error("prei_adr_cnt: clr_i and inc_i in same cycle");

endmodule

// ==== hw/prei_ram_dp_16x32.sv ====
// prei_ram_dp_16x32: two-port 16x32 original-pixel register file, active-low enables

module prei_ram_dp_16x32
	import prei_pkg::*;
(
	input  logic  clk,
	input  logic  wr_ena_i, // low active
	input  adr_t  wr_adr_i,
	input  word_t wr_dat_i,
	input  logic  rd_ena_i, // low active
	input  adr_t  rd_adr_i,
	output word_t rd_dat_o  // valid one cycle after rd_ena_i low
);

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------

	word_t mem [WORDS_PER_BLK]; // one 8x8 block
	word_t rd_dat;              // registered read word

	// write port b, read port a
	// both in one block so a same-address read sees the old word
	always_ff @(posedge clk) begin
		if (!wr_ena_i) begin
			mem[wr_adr_i] <= wr_dat_i;
		end
		if (!rd_ena_i) begin
			rd_dat <= mem[rd_adr_i]; // holds when not reading
		end
	end

	assign rd_dat_o = rd_dat;

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	// no reset pin here, so "after reset" means once the controller
	// has driven known enables they must stay known
	ena_known_a : assert property (
		@(posedge clk)
		!$isunknown({wr_ena_i, rd_ena_i}) |=> !$isunknown({wr_ena_i, rd_ena_i})
	) else $error("prei_ram: enable went unknown");

endmodule

// ==== hw/prei_pkg.sv ====
// prei package: width typedefs, 8x8 block constants, controller state enum

package prei_pkg;

	// ------------------------------------------------------------
	// widths with a meaning
	// ------------------------------------------------------------

	typedef logic [7:0]  pix_t;  // one luma pixel
	typedef logic [31:0] word_t; // four pixels, first one in low byte
	typedef logic [3:0]  adr_t;  // ram word address
	typedef logic [13:0] sum_t;  // block pixel sum, max 64*255
	typedef logic [13:0] sad_t;  // block sad, same bound as the sum

	// ------------------------------------------------------------
	// block format
	// ------------------------------------------------------------

	localparam int PIX_PER_WORD  = 4;  // pixels packed per ram word
	localparam int WORDS_PER_BLK = 16; // 8x8 block = 16 words
	localparam int LAST_ADR      = 15; // last word of a pass

	// dc = (sum + 32) >> 6, i.e. rounded mean of 64 pixels
	localparam int DC_SHIFT = 6;
	localparam int DC_ROUND = 32;

	// ------------------------------------------------------------
	// controller states
	// ------------------------------------------------------------

	typedef enum logic [2:0] {
		IDLE, // waiting for start
		LOAD, // loader writes 16 words
		SUM,  // first read pass, dc
		SAD,  // second read pass, cost
		DONE  // one-cycle result strobe
	} prei_state_e;

endpackage
